//--- ramUnit.f
+incdir+.
ramUnitPkg.sv
ramCmdQueue.sv
ramBankCtrl.sv
ramReadMerge.sv
ramUnit.sv
tbSramModel.sv
tbRamUnit.sv

//--- tbRamUnit.sv
//--------------------
// SRAM controller testbench
// Directed and random traffic against a shadow memory
// Checks order, back-pressure, reset state and strobes
//--------------------
`include "ramUnit_params.svh"

module tbRamUnit;
timeunit 1ns;
timeprecision 100ps;

localparam int RandCmds		= 300;
localparam int TotalCmds	= 20 + 32 + 24 + RandCmds;		// All tests together
localparam int StatW		= 2 + 3 * `RAM_BANKS;

logic									sysClk;
logic									rstN;
logic									cmdValid;
logic									cmdReady;
logic									cmdRead;
ramUnitPkg::busAdrs_t					cmdAdrs;
ramUnitPkg::ramData_t					cmdWrData;
logic									rdValid;
logic									rdReady;
ramUnitPkg::ramData_t					rdData;
ramUnitPkg::ramAdrs_t [`RAM_BANKS-1:0]	memAdrs;
wire ramUnitPkg::ramData_t [`RAM_BANKS-1:0]	memDq;
logic [`RAM_BANKS-1:0]					memCeN;
logic [`RAM_BANKS-1:0]					memOeN;
logic [`RAM_BANKS-1:0]					memWeN;
logic [`RAM_BANKS-1:0]					oeWeClash;
logic [`RAM_BANKS-1:0]					dqClash;

//--------------------
// Scoreboard state
//--------------------
ramUnitPkg::ramData_t	shadow [`RAM_BANKS][1 << `RAM_ADRS_WIDTH];
ramUnitPkg::ramData_t	expQ [$];		// Expected read data, issue order
string					nameQ [$];		// Test that issued each read
string					curTest;
logic					sawFull;		// cmdReady seen low
logic					stallMode;		// Random rdReady
logic					rstSeen = 1'b0;	// Reset was low at last edge
logic [StatW-1:0]		resetStatus;

ramUnit ramUnit_i (
	.sysClk		(sysClk),
	.rstN		(rstN),
	.cmdValid	(cmdValid),
	.cmdReady	(cmdReady),
	.cmdRead	(cmdRead),
	.cmdAdrs	(cmdAdrs),
	.cmdWrData	(cmdWrData),
	.rdValid	(rdValid),
	.rdReady	(rdReady),
	.rdData		(rdData),
	.memAdrs	(memAdrs),
	.memDq		(memDq),
	.memCeN		(memCeN),
	.memOeN		(memOeN),
	.memWeN		(memWeN)
);

for (genvar b = 0; b < `RAM_BANKS; b++) begin : genChip
	tbSramModel #(.BankIdx(b)) tbSramModel_i (
		.memAdrs	(memAdrs[b]),
		.memDq		(memDq[b]),
		.memCeN		(memCeN[b]),
		.memOeN		(memOeN[b]),
		.memWeN		(memWeN[b]),
		.oeWeClash	(oeWeClash[b]),
		.dqClash	(dqClash[b])
	);
end

initial begin
	sysClk = 1'b0;
	forever #10 sysClk = ~sysClk;		// 20 ns period
end

//--------------------
// Failure reporting
//--------------------
task automatic abortRun();
	$display("** FAIL **");
	$fatal(1, "run stopped at first error");
endtask

task automatic mismatch(input string name, input logic [31:0] expV, input logic [31:0] actV);
	$display("ERR %s expected %h actual %h", name, expV, actV);
	abortRun();
endtask

task automatic complain(input string msg);
	$display("%s", msg);
	abortRun();
endtask

// Quiet outputs during and right after reset
assign resetStatus = {rdValid, cmdReady, memCeN, memOeN, memWeN};
always @(posedge sysClk) rstSeen <= !rstN;

assert property (@(posedge sysClk) rstSeen |-> (resetStatus === {2'b01, {(3*`RAM_BANKS){1'b1}}}))
	else mismatch("resetState", {2'b01, {(3*`RAM_BANKS){1'b1}}}, $sampled(resetStatus));

// Stalled response must hold
assert property (@(posedge sysClk) disable iff (!rstN)
		(rdValid && !rdReady) |=> (rdValid && $stable(rdData)))
	else complain("response changed or vanished while rdReady was low");

// Strobe legality from the chip models
assert property (@(posedge sysClk) oeWeClash == '0)
	else complain("OE and WE were low together on an SRAM chip");
assert property (@(posedge sysClk) dqClash == '0)
	else complain("controller drove the data bus while OE was low");

// Response compare against issue order
always @(posedge sysClk) begin
	if (rstN && rdValid && rdReady) begin
		if (expQ.size() == 0) begin
			complain("read response arrived with no read outstanding");
		end else begin
			assert (rdData === expQ[0]) begin
				void'(expQ.pop_front());
				void'(nameQ.pop_front());
			end else mismatch(nameQ[0], expQ[0], rdData);
		end
	end
end

//--------------------
// Stimulus helpers
//--------------------
task automatic nextCycle();
	@(negedge sysClk);
	rdReady = stallMode ? ($urandom % 2 == 0) : 1'b1;
endtask

// Call at a falling edge, returns at a falling edge
task automatic sendCmd(input logic isRead, input int bank, input int word,
		input ramUnitPkg::ramData_t data);
	ramUnitPkg::busAdrs_t	adrs;
	logic					taken;
	adrs = ramUnitPkg::busAdrs_t'($urandom);		// High bits are don't care
	adrs[`RAM_ADRS_WIDTH-1:0] = ramUnitPkg::ramAdrs_t'(word);
	adrs[`RAM_ADRS_WIDTH +: $bits(ramUnitPkg::bankSel_t)] = ramUnitPkg::bankSel_t'(bank);
	cmdValid	= 1'b1;
	cmdRead		= isRead;
	cmdAdrs		= adrs;
	cmdWrData	= data;
	do begin
		taken = cmdReady;		// Registered, stable until next edge
		if (!taken) sawFull = 1'b1;
		@(posedge sysClk);
		if (!taken) nextCycle();
	end while (!taken);
	if (isRead) begin
		expQ.push_back(shadow[bank][word]);		// Same-bank order gives RAW
		nameQ.push_back(curTest);
	end else begin
		shadow[bank][word] = data;
	end
	nextCycle();
	cmdValid = 1'b0;
endtask

task automatic drain();
	stallMode = 1'b0;
	while (expQ.size() != 0) nextCycle();
endtask

// Watchdog sized from the command count
initial begin
	repeat (TotalCmds * 40 + 1000) @(posedge sysClk);
	complain("watchdog expired before the tests finished");
end

//--------------------
// Test sequence
//--------------------
initial begin
	rstN		= 1'b0;
	cmdValid	= 1'b0;
	cmdRead		= 1'b0;
	cmdAdrs		= '0;
	cmdWrData	= '0;
	rdReady		= 1'b1;
	stallMode	= 1'b0;
	sawFull		= 1'b0;
	curTest		= "reset";
	void'($urandom(53142));
	for (int b = 0; b < `RAM_BANKS; b++) begin
		for (int w = 0; w < (1 << `RAM_ADRS_WIDTH); w++) begin
			shadow[b][w] = ramUnitPkg::ramData_t'(w ^ b);	// Model fill rule
		end
	end
	repeat (5) @(posedge sysClk);
	nextCycle();
	rstN = 1'b1;
	repeat (3) nextCycle();

	// Write then read, plus unwritten words
	curTest = "writeRead";
	for (int b = 0; b < `RAM_BANKS; b++) begin
		sendCmd(1'b0, b, 3, ramUnitPkg::ramData_t'($urandom));
		sendCmd(1'b1, b, 3, '0);
		sendCmd(1'b0, b, 77, ramUnitPkg::ramData_t'($urandom));
		sendCmd(1'b1, b, 77, '0);
		sendCmd(1'b0, b, 512, ramUnitPkg::ramData_t'($urandom));
		sendCmd(1'b1, b, 512, '0);
		sendCmd(1'b0, b, 1023, ramUnitPkg::ramData_t'($urandom));
		sendCmd(1'b1, b, 1023, '0);
		sendCmd(1'b1, b, 200, '0);		// Fill pattern
		sendCmd(1'b1, b, 900, '0);
	end
	drain();

	// Alternating banks, back to back
	curTest = "crossBank";
	for (int i = 0; i < 8; i++) begin
		sendCmd(1'b0, 0, 20 + i, ramUnitPkg::ramData_t'($urandom));
		sendCmd(1'b0, 1, 20 + i, ramUnitPkg::ramData_t'($urandom));
	end
	for (int i = 0; i < 8; i++) begin
		sendCmd(1'b1, 0, 20 + i, '0);
		sendCmd(1'b1, 1, 20 + i, '0);
	end
	drain();

	// Reads under random rdReady
	curTest = "backPressure";
	stallMode = 1'b1;
	for (int i = 0; i < 24; i++) begin
		sendCmd(1'b1, i % 2, (i * 37) % 1024, '0);
	end
	drain();

	// Random mix, small word range for hits
	curTest = "randomTraffic";
	stallMode = 1'b1;
	for (int n = 0; n < RandCmds; n++) begin
		int						gap;
		logic					isRead;
		int						bank;
		int						word;
		ramUnitPkg::ramData_t	data;
		gap		= ($urandom % 4 == 0) ? $urandom_range(3, 1) : 0;
		isRead	= ($urandom % 2 == 1);
		bank	= $urandom % `RAM_BANKS;
		word	= $urandom % 64;
		data	= ramUnitPkg::ramData_t'($urandom);
		repeat (gap) nextCycle();
		sendCmd(isRead, bank, word, data);
	end
	drain();
	repeat (10) nextCycle();

	if (!sawFull || !cmdReady) begin
		complain("command FIFO never filled, or cmdReady did not recover");
	end else begin
		$display("** PASS **");
		$finish;
	end
end

endmodule

//--- tbSramModel.sv
//--------------------
// Async SRAM chip model
// Word array with address fill, flags strobe misuse
//--------------------
`include "ramUnit_params.svh"

module tbSramModel #(
	parameter int BankIdx = 0						// Used in the fill pattern
) (
	input	ramUnitPkg::ramAdrs_t			memAdrs,
	inout	wire ramUnitPkg::ramData_t		memDq,
	input	logic							memCeN,
	input	logic							memOeN,
	input	logic							memWeN,
	output	logic							oeWeClash,		// OE and WE low together
	output	logic							dqClash			// Bus fight during a read
);
timeunit 1ns;
timeprecision 100ps;

ramUnitPkg::ramData_t	mem [1 << `RAM_ADRS_WIDTH];
logic					reading;

// Fill is word index XOR bank
initial begin
	for (int w = 0; w < (1 << `RAM_ADRS_WIDTH); w++) begin
		mem[w] = ramUnitPkg::ramData_t'(w ^ BankIdx);
	end
end

assign reading	= (memCeN === 1'b0) && (memOeN === 1'b0);
assign memDq	= reading ? mem[memAdrs] : 'z;		// Chip drives only under OE

// Level-sensitive write while WE is low
always @(memCeN, memWeN, memAdrs, memDq) begin
	if (memCeN === 1'b0 && memWeN === 1'b0) begin
		mem[memAdrs] = memDq;
	end
end

assign oeWeClash	= (memOeN === 1'b0) && (memWeN === 1'b0);
assign dqClash		= reading && (memDq !== mem[memAdrs]);	// Second driver shows as X

endmodule

//--- ramUnit.sv
//--------------------
// Multi-bank async SRAM controller
// Command queue, one bank controller per chip, in-order read merge
//--------------------
`include "ramUnit_params.svh"

module ramUnit (
	input	logic										sysClk,
	input	logic										rstN,
	// Bus command
	input	logic										cmdValid,
	output	logic										cmdReady,
	input	logic										cmdRead,	// High read, low write
	input	ramUnitPkg::busAdrs_t						cmdAdrs,
	input	ramUnitPkg::ramData_t						cmdWrData,
	// Read response
	output	logic										rdValid,
	input	logic										rdReady,
	output	ramUnitPkg::ramData_t						rdData,
	// SRAM pins, one slice per bank
	output	ramUnitPkg::ramAdrs_t [`RAM_BANKS-1:0]		memAdrs,
	inout	wire ramUnitPkg::ramData_t [`RAM_BANKS-1:0]	memDq,
	output	logic [`RAM_BANKS-1:0]						memCeN,
	output	logic [`RAM_BANKS-1:0]						memOeN,
	output	logic [`RAM_BANKS-1:0]						memWeN
);

//--------------------
// Internal wires
//--------------------
logic [`RAM_BANKS-1:0]					bankCmdValid;
logic [`RAM_BANKS-1:0]					bankCmdReady;
logic									bankCmdRead;
ramUnitPkg::ramAdrs_t					bankCmdAdrs;
ramUnitPkg::ramData_t					bankCmdWrData;
logic									tagValid;
logic									tagReady;
ramUnitPkg::bankSel_t					tagBank;
logic [`RAM_BANKS-1:0]					bankRdValid;
logic [`RAM_BANKS-1:0]					bankRdReady;
ramUnitPkg::ramData_t [`RAM_BANKS-1:0]	bankRdData;

ramCmdQueue ramCmdQueue_i (
	.sysClk			(sysClk),
	.rstN			(rstN),
	.cmdValid		(cmdValid),
	.cmdReady		(cmdReady),
	.cmdRead		(cmdRead),
	.cmdAdrs		(cmdAdrs),
	.cmdWrData		(cmdWrData),
	.bankCmdValid	(bankCmdValid),
	.bankCmdReady	(bankCmdReady),
	.bankCmdRead	(bankCmdRead),
	.bankCmdAdrs	(bankCmdAdrs),
	.bankCmdWrData	(bankCmdWrData),
	.tagValid		(tagValid),
	.tagReady		(tagReady),
	.tagBank		(tagBank)
);

// One controller per chip, command data broadcast
for (genvar b = 0; b < `RAM_BANKS; b++) begin : genBank
	ramBankCtrl ramBankCtrl_i (
		.sysClk		(sysClk),
		.rstN		(rstN),
		.cmdValid	(bankCmdValid[b]),
		.cmdReady	(bankCmdReady[b]),
		.cmdRead	(bankCmdRead),
		.cmdAdrs	(bankCmdAdrs),
		.cmdWrData	(bankCmdWrData),
		.rdValid	(bankRdValid[b]),
		.rdReady	(bankRdReady[b]),
		.rdData		(bankRdData[b]),
		.memAdrs	(memAdrs[b]),
		.memDq		(memDq[b]),
		.memCeN		(memCeN[b]),
		.memOeN		(memOeN[b]),
		.memWeN		(memWeN[b])
	);
end

ramReadMerge ramReadMerge_i (
	.sysClk			(sysClk),
	.rstN			(rstN),
	.tagValid		(tagValid),
	.tagReady		(tagReady),
	.tagBank		(tagBank),
	.bankRdValid	(bankRdValid),
	.bankRdReady	(bankRdReady),
	.bankRdData		(bankRdData),
	.rdValid		(rdValid),
	.rdReady		(rdReady),
	.rdData			(rdData)
);

endmodule

//--- ramReadMerge.sv
//--------------------
// Read merge
// Returns bank read results in issue order
// Bank tag FIFO picks which bank may hand over next
//--------------------
`include "ramUnit_params.svh"

module ramReadMerge (
	input	logic										sysClk,
	input	logic										rstN,
	// Tag push from queue
	input	logic										tagValid,
	output	logic										tagReady,
	input	ramUnitPkg::bankSel_t						tagBank,
	// Bank results
	input	logic [`RAM_BANKS-1:0]						bankRdValid,
	output	logic [`RAM_BANKS-1:0]						bankRdReady,
	input	ramUnitPkg::ramData_t [`RAM_BANKS-1:0]		bankRdData,
	// Response port
	output	logic										rdValid,
	input	logic										rdReady,
	output	ramUnitPkg::ramData_t						rdData
);

localparam int PtrW = $clog2(`RD_TAG_DEPTH);
localparam int CntW = $clog2(`RD_TAG_DEPTH + 1);

//--------------------
// Tag FIFO
//--------------------
ramUnitPkg::bankSel_t	tagMem [`RD_TAG_DEPTH];
logic [PtrW-1:0]		tagWrPtr;
logic [PtrW-1:0]		tagRdPtr;
logic [CntW-1:0]		tagCount;

logic					tagPush;
logic					tagPop;
logic					outFree;		// Output register can take a word
ramUnitPkg::bankSel_t	headTag;

assign tagReady	= (tagCount != CntW'(`RD_TAG_DEPTH));
assign tagPush	= tagValid && tagReady;
assign headTag	= tagMem[tagRdPtr];
assign outFree	= !rdValid || rdReady;

// Only the head tag's bank may deliver
always_comb begin
	for (int b = 0; b < `RAM_BANKS; b++) begin
		bankRdReady[b] = (tagCount != '0) && outFree
						&& (headTag == ramUnitPkg::bankSel_t'(b));
	end
end

assign tagPop = |(bankRdValid & bankRdReady);	// Result taken, tag retires

always_ff @(posedge sysClk) begin
	if (tagPush) begin
		tagMem[tagWrPtr] <= tagBank;
	end
end

always_ff @(posedge sysClk) begin
	if (!rstN) begin
		tagWrPtr	<= '0;
		tagRdPtr	<= '0;
		tagCount	<= '0;
		rdValid		<= 1'b0;
	end else begin
		if (tagPush) begin
			tagWrPtr <= (tagWrPtr == PtrW'(`RD_TAG_DEPTH-1)) ? '0 : tagWrPtr + 1'b1;
		end
		if (tagPop) begin
			tagRdPtr <= (tagRdPtr == PtrW'(`RD_TAG_DEPTH-1)) ? '0 : tagRdPtr + 1'b1;
		end
		tagCount <= tagCount + CntW'(tagPush) - CntW'(tagPop);

		// Output valid
		if (tagPop) begin
			rdValid <= 1'b1;
		end else if (rdReady) begin
			rdValid <= 1'b0;
		end
	end
end

// Output word, stable while stalled
always_ff @(posedge sysClk) begin
	if (tagPop) begin
		rdData <= bankRdData[headTag];
	end
end

endmodule

//--- ramBankCtrl.sv
//--------------------
// SRAM bank controller
// Drives CE, OE, WE strobes of one async SRAM chip
// Owns the tristate data bus, captures read data
//--------------------
`include "ramUnit_params.svh"

module ramBankCtrl (
	input	logic							sysClk,
	input	logic							rstN,
	// Command from queue
	input	logic							cmdValid,
	output	logic							cmdReady,		// Idle only
	input	logic							cmdRead,
	input	ramUnitPkg::ramAdrs_t			cmdAdrs,
	input	ramUnitPkg::ramData_t			cmdWrData,
	// Read result to merge
	output	logic							rdValid,
	input	logic							rdReady,
	output	ramUnitPkg::ramData_t			rdData,
	// SRAM pins
	output	ramUnitPkg::ramAdrs_t			memAdrs,
	inout	wire ramUnitPkg::ramData_t		memDq,
	output	logic							memCeN,			// Chip enable
	output	logic							memOeN,			// Output enable
	output	logic							memWeN			// Write enable
);

localparam int StbW = $clog2(`RAM_STROBE_CYCLES + 1);
localparam logic [StbW-1:0] StbLast = StbW'(`RAM_STROBE_CYCLES - 1);

ramUnitPkg::bankState_t	state;
logic [StbW-1:0]		stbCnt;		// Strobe cycles spent

ramUnitPkg::ramAdrs_t	adrsReg;
ramUnitPkg::ramData_t	dataReg;
logic					readReg;	// Direction of the running access

logic					accept;
logic					busy;		// CE window
logic					strobe;
logic					lastStrobe;
logic					driveDq;

assign accept		= cmdValid && cmdReady;
assign busy			= (state == ramUnitPkg::stSetup) || (state == ramUnitPkg::stStrobe)
					|| (state == ramUnitPkg::stHold);
assign strobe		= (state == ramUnitPkg::stStrobe);
assign lastStrobe	= strobe && (stbCnt == StbLast);

//--------------------
// Sequencer
//--------------------
always_ff @(posedge sysClk) begin
	if (!rstN) begin
		state	<= ramUnitPkg::stIdle;
		stbCnt	<= '0;
	end else begin
		case (state)
			ramUnitPkg::stIdle: begin
				if (cmdValid) begin
					state <= ramUnitPkg::stSetup;
				end
			end
			ramUnitPkg::stSetup: begin
				state	<= ramUnitPkg::stStrobe;
				stbCnt	<= '0;
			end
			ramUnitPkg::stStrobe: begin
				if (stbCnt == StbLast) begin
					state <= ramUnitPkg::stHold;
				end else begin
					stbCnt <= stbCnt + 1'b1;
				end
			end
			ramUnitPkg::stHold: begin
				// Writes are done here
				state <= readReg ? ramUnitPkg::stRespond : ramUnitPkg::stIdle;
			end
			ramUnitPkg::stRespond: begin
				if (rdReady) begin
					state <= ramUnitPkg::stIdle;
				end
			end
			default: state <= ramUnitPkg::stIdle;
		endcase
	end
end

// Access payload, latched at acceptance
always_ff @(posedge sysClk) begin
	if (accept) begin
		adrsReg	<= cmdAdrs;
		dataReg	<= cmdWrData;
		readReg	<= cmdRead;
	end
	if (lastStrobe && readReg) begin
		rdData <= memDq;		// Sample at end of OE window
	end
end

//--------------------
// Pin decode
//--------------------
assign cmdReady	= (state == ramUnitPkg::stIdle);
assign rdValid	= (state == ramUnitPkg::stRespond);	// Held until merge takes it

assign memAdrs	= adrsReg;
assign memCeN	= !busy;
assign memOeN	= !(strobe && readReg);
assign memWeN	= !(strobe && !readReg);

// Write data covers setup through hold
assign driveDq	= busy && !readReg;
assign memDq	= driveDq ? dataReg : 'z;

endmodule

//--- ramCmdQueue.sv
//--------------------
// Command queue
// Buffers bus commands, issues them in order to the addressed bank
// Read issue also pushes the bank tag to the read merge
//--------------------
`include "ramUnit_params.svh"

module ramCmdQueue (
	input	logic							sysClk,
	input	logic							rstN,
	// Bus command
	input	logic							cmdValid,
	output	logic							cmdReady,
	input	logic							cmdRead,		// High read, low write
	input	ramUnitPkg::busAdrs_t			cmdAdrs,
	input	ramUnitPkg::ramData_t			cmdWrData,
	// Bank issue
	output	logic [`RAM_BANKS-1:0]			bankCmdValid,	// One hot, head bank only
	input	logic [`RAM_BANKS-1:0]			bankCmdReady,
	output	logic							bankCmdRead,	// Broadcast
	output	ramUnitPkg::ramAdrs_t			bankCmdAdrs,	// Broadcast
	output	ramUnitPkg::ramData_t			bankCmdWrData,	// Broadcast
	// Read tag push
	output	logic							tagValid,
	input	logic							tagReady,
	output	ramUnitPkg::bankSel_t			tagBank
);

localparam int PtrW = $clog2(`CMD_QUEUE_DEPTH);
localparam int CntW = $clog2(`CMD_QUEUE_DEPTH + 1);

//--------------------
// Storage
//--------------------
ramUnitPkg::bankSel_t	qBank [`CMD_QUEUE_DEPTH];	// Decoded at the top
ramUnitPkg::ramAdrs_t	qAdrs [`CMD_QUEUE_DEPTH];
ramUnitPkg::ramData_t	qData [`CMD_QUEUE_DEPTH];
logic					qRead [`CMD_QUEUE_DEPTH];

logic [PtrW-1:0]		wrPtr;
logic [PtrW-1:0]		rdPtr;
logic [CntW-1:0]		count;			// Entries held

logic					push;
logic					pop;
logic					notEmpty;
logic					headRead;
logic					headGo;			// Head may be offered
ramUnitPkg::bankSel_t	headBank;

assign cmdReady	= (count != CntW'(`CMD_QUEUE_DEPTH));	// Low only when full
assign push		= cmdValid && cmdReady;
assign notEmpty	= (count != '0);

// Head entry
assign headBank			= qBank[rdPtr];
assign headRead			= qRead[rdPtr];
assign bankCmdRead		= headRead;
assign bankCmdAdrs		= qAdrs[rdPtr];
assign bankCmdWrData	= qData[rdPtr];

// Reads wait for room in the tag FIFO
assign headGo = notEmpty && (!headRead || tagReady);

always_comb begin
	for (int b = 0; b < `RAM_BANKS; b++) begin
		bankCmdValid[b] = headGo && (headBank == ramUnitPkg::bankSel_t'(b));
	end
end

assign pop		= |(bankCmdValid & bankCmdReady);
assign tagValid	= pop && headRead;		// Same cycle as the read issue
assign tagBank	= headBank;

// Bank field sits right above the chip address
always_ff @(posedge sysClk) begin
	if (push) begin
		qBank[wrPtr] <= cmdAdrs[`RAM_ADRS_WIDTH +: $bits(ramUnitPkg::bankSel_t)];
		qAdrs[wrPtr] <= cmdAdrs[`RAM_ADRS_WIDTH-1:0];
		qData[wrPtr] <= cmdWrData;
		qRead[wrPtr] <= cmdRead;
	end
end

//--------------------
// Pointers
//--------------------
always_ff @(posedge sysClk) begin
	if (!rstN) begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
	end else begin
		if (push) begin
			wrPtr <= (wrPtr == PtrW'(`CMD_QUEUE_DEPTH-1)) ? '0 : wrPtr + 1'b1;
		end
		if (pop) begin
			rdPtr <= (rdPtr == PtrW'(`CMD_QUEUE_DEPTH-1)) ? '0 : rdPtr + 1'b1;
		end
		count <= count + CntW'(push) - CntW'(pop);
	end
end

endmodule

//--- ramUnitPkg.sv
//--------------------
// SRAM controller types
// Data, address and bank vectors, bank FSM states
//--------------------
`include "ramUnit_params.svh"

package ramUnitPkg;

	typedef logic [`RAM_DQ_WIDTH-1:0]			ramData_t;	// One data word
	typedef logic [`RAM_ADRS_WIDTH-1:0]			ramAdrs_t;	// In-chip word address
	typedef logic [`BUS_ADRS_WIDTH-1:0]			busAdrs_t;	// Slave bus address
	typedef logic [$clog2(`RAM_BANKS)-1:0]		bankSel_t;	// Bank index

	// Bank strobe sequencer
	typedef enum logic [2:0] {
		stIdle,		// Ready for a command
		stSetup,	// CE low, address settles
		stStrobe,	// OE or WE low
		stHold,		// Strobes released
		stRespond	// Read data waiting for merge
	} bankState_t;

endpackage

//--- ramUnit_params.svh
//--------------------
// SRAM controller parameters
// Bank count, widths, queue depths, strobe timing
//--------------------
`ifndef RAM_UNIT_PARAMS_SVH
`define RAM_UNIT_PARAMS_SVH

`define RAM_BANKS			2	// SRAM chips, one bank each
`define RAM_DQ_WIDTH		16	// Bus and SRAM data width
`define RAM_ADRS_WIDTH		10	// Word address inside one chip
`define BUS_ADRS_WIDTH		32	// Slave bus address

`define CMD_QUEUE_DEPTH		4	// Command FIFO entries
`define RD_TAG_DEPTH		8	// Outstanding read tags

`define RAM_STROBE_CYCLES	2	// OE or WE low time

`endif
